/* bench/dataCacheTb.sv */
`timescale 1ns/1ps

module dataCacheTb;

	localparam logic [1:0] opRead  = 2'd0;
	localparam logic [1:0] opWrite = 2'd1;
	localparam logic [1:0] opHalt  = 2'd2;
	localparam logic [1:0] expAny  = 2'd0;  // latency not predicted for this step
	localparam logic [1:0] expHit  = 2'd1;
	localparam logic [1:0] expMiss = 2'd2;

	typedef struct packed {
		logic [1:0]      op;
		logic [1:0]      hitExp;  // whether the request should hit at once
		cachePkg::word_t addr;
		cachePkg::word_t store;
	} step_t;

	localparam int stepCount = 40;
	// a miss costs at most four transfers of four cycles, a flushed frame at most nine
	localparam int cycleLimit = stepCount * 20 + 16 * 10 + 20;

	// tags 1, 2 and 3 share each index so the third one forces an eviction
	localparam step_t steps [stepCount] = '{
		'{opRead,  expMiss, 32'h00000040, 32'h0},          // set 0, tag A fills way 0
		'{opRead,  expHit,  32'h00000044, 32'h0},          // other word of the same block
		'{opWrite, expHit,  32'h00000040, 32'h11110000},
		'{opRead,  expHit,  32'h00000040, 32'h0},
		'{opRead,  expMiss, 32'h00000080, 32'h0},          // tag B fills way 1
		'{opWrite, expHit,  32'h00000084, 32'h22220001},
		'{opRead,  expHit,  32'h00000040, 32'h0},          // touching A leaves B as LRU
		'{opRead,  expMiss, 32'h000000c0, 32'h0},          // C evicts the dirty B
		'{opRead,  expHit,  32'h00000040, 32'h0},          // A survived the eviction
		'{opRead,  expMiss, 32'h00000084, 32'h0},          // B comes back from memory
		'{opWrite, expMiss, 32'h00000058, 32'h33330000},   // set 3, write misses
		'{opWrite, expHit,  32'h0000005c, 32'h33330001},
		'{opWrite, expMiss, 32'h00000098, 32'h44440000},
		'{opWrite, expMiss, 32'h000000d8, 32'h55550000},   // dirty A goes out
		'{opRead,  expMiss, 32'h00000058, 32'h0},          // dirty B goes out, A reloads
		'{opRead,  expHit,  32'h0000005c, 32'h0},
		'{opRead,  expMiss, 32'h0000009c, 32'h0},
		'{opRead,  expHit,  32'h00000098, 32'h0},
		'{opRead,  expMiss, 32'h000000d8, 32'h0},
		'{opWrite, expMiss, 32'hfffffff8, 32'ha5a5a5a5},   // set 7 with extreme tags
		'{opRead,  expHit,  32'hfffffffc, 32'h0},
		'{opWrite, expMiss, 32'h00000038, 32'h12345678},
		'{opRead,  expHit,  32'h0000003c, 32'h0},
		'{opRead,  expMiss, 32'h80000038, 32'h0},
		'{opRead,  expMiss, 32'hfffffff8, 32'h0},
		'{opRead,  expMiss, 32'h00000038, 32'h0},
		'{opRead,  expMiss, 32'h00000048, 32'h0},          // set 1
		'{opWrite, expHit,  32'h0000004c, 32'h0badf00d},
		'{opRead,  expHit,  32'h0000004c, 32'h0},
		'{opWrite, expHit,  32'h00000048, 32'h600dcafe},
		'{opWrite, expMiss, 32'h00000088, 32'h77770000},
		'{opRead,  expHit,  32'h0000008c, 32'h0},
		'{opWrite, expMiss, 32'h000000c8, 32'h88880000},
		'{opRead,  expMiss, 32'h00000048, 32'h0},
		'{opRead,  expHit,  32'h0000004c, 32'h0},
		'{opWrite, expHit,  32'h00000044, 32'h99990001},   // set 0 again
		'{opRead,  expMiss, 32'h000000c4, 32'h0},          // clean B is replaced
		'{opWrite, expHit,  32'h000000c0, 32'hcccc0000},
		'{opRead,  expMiss, 32'h00000068, 32'h0},          // set 5, never touched before
		'{opHalt,  expAny,  32'h00000000, 32'h0}
	};

	logic              CLK;
	logic              rst;
	logic              halt;
	logic              dhit;
	logic              flushed;
	logic              dwait;
	cachePkg::dpReq_t  dpReq;
	cachePkg::memReq_t memReq;
	cachePkg::word_t   dload;
	cachePkg::word_t   dmemLoad;

	cachePkg::word_t memWords [cachePkg::word_t];  // only words written so far
	cachePkg::word_t refWords [cachePkg::word_t];  // latest value the datapath stored
	integer seed = 32'hdf5a9fb3;
	int     waitLeft;
	logic   busy;  // a transfer has been accepted and is counting down
	int     cycleCount = 0;
	int     errorCount = 0;

	dataCache dut0
	(
		.CLK      (CLK),
		.rst      (rst),
		.dpReq    (dpReq),
		.halt     (halt),
		.dhit     (dhit),
		.dmemLoad (dmemLoad),
		.flushed  (flushed),
		.memReq   (memReq),
		.dload    (dload),
		.dwait    (dwait)
	);

	bind dataCache dataCacheChecker checker0
	(
		.CLK     (CLK),
		.rst     (rst),
		.halt    (halt),
		.dhit    (dhit),
		.flushed (flushed),
		.dwait   (dwait),
		.memReq  (memReq)
	);

	initial
	begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want)
		begin
			errorCount++;
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, want);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	// memory that was never written holds a pattern of its own address
	function automatic cachePkg::word_t memRead(input cachePkg::word_t addr);
		return memWords.exists(addr) ? memWords[addr] : (addr ^ 32'h5a5a0000);
	endfunction

	function automatic cachePkg::word_t refRead(input cachePkg::word_t addr);
		return refWords.exists(addr) ? refWords[addr] : (addr ^ 32'h5a5a0000);
	endfunction

	// memory model, each transfer waits a random 0 to 3 cycles before it completes
	always @(negedge CLK)
	begin
		if (rst)
		begin
			busy  = 1'b0;
			dwait = 1'b1;
		end
		else if (memReq.read || memReq.write)
		begin
			if (!busy)
			begin
				busy     = 1'b1;
				waitLeft = $unsigned($random(seed)) % 4;
			end
			if (memReq.read)
				dload = memRead(memReq.addr);
			if (waitLeft > 0)
			begin
				dwait = 1'b1;
				waitLeft--;
			end
			else
			begin
				dwait = 1'b0;  // the transfer completes at the coming rising edge
				busy  = 1'b0;
				if (memReq.write)
					memWords[memReq.addr] = memReq.store;
			end
		end
		else
			dwait = 1'b1;
		if (flushed)
			check("memReq after flushed", 32'({memReq.read, memReq.write}), 32'd0);
	end

	always @(posedge CLK)
	begin
		cycleCount++;
		if (cycleCount > cycleLimit)
		begin
			$display("timeout: the cache did not finish the stimulus within %0d cycles",
				cycleLimit);
			$display("Finished with errors");
			$fatal(1);
		end
	end

	// raise halt, wait for the flush and compare memory with every stored word
	task automatic flushAndCompare();
		halt  = 1'b1;
		dpReq = '0;
		#1;
		while (!flushed)
		begin
			@(negedge CLK);
			#1;
		end
		repeat (4) @(negedge CLK);  // memory stays quiet after the flush
		foreach (refWords[a])
			check($sformatf("memory[%h]", a), memRead(a), refWords[a]);
	endtask

	task automatic runStep(input step_t s);
		@(negedge CLK);
		if (s.op == opHalt)
			flushAndCompare();
		else
		begin
			dpReq.read  = (s.op == opRead);
			dpReq.write = (s.op == opWrite);
			dpReq.addr  = s.addr;
			dpReq.store = s.store;
			#1;
			if (s.hitExp == expHit)
			begin
				check("dhit", 32'(dhit), 32'd1);
				check("memReq.read", 32'(memReq.read), 32'd0);
				check("memReq.write", 32'(memReq.write), 32'd0);
			end
			else if (s.hitExp == expMiss)
				check("dhit", 32'(dhit), 32'd0);
			while (!dhit)
			begin
				@(negedge CLK);
				#1;
			end
			// the request is taken at the next rising edge
			if (s.op == opRead)
				check($sformatf("dmemLoad[%h]", s.addr), dmemLoad, refRead(s.addr));
			else
				refWords[s.addr] = s.store;
		end
	endtask

	initial
	begin
		rst   = 1'b1;
		halt  = 1'b0;
		dpReq = '0;
		dload = '0;
		dwait = 1'b1;
		repeat (10) @(negedge CLK);
		rst = 1'b0;
		for (int i = 0; i < stepCount; i++)
			runStep(steps[i]);
		if (errorCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* bench/dataCache_checker.sv */
`timescale 1ns/1ps

module dataCacheChecker
(
	input logic                CLK,
	input logic                rst,
	input logic                halt,
	input logic                dhit,
	input logic                flushed,
	input logic                dwait,
	input cachePkg::memReq_t   memReq
);

	// the memory port carries one transfer direction at a time
	oneDirection: assert property (@(posedge CLK) disable iff (rst)
		!(memReq.read && memReq.write))
		else $error("memory read and write requested together");

	// a stalled request must not move until memory lets it through
	heldWhileWaiting: assert property (@(posedge CLK) disable iff (rst)
		((memReq.read || memReq.write) && dwait) |=> $stable(memReq))
		else $error("memory request changed while dwait was high");

	// a flush only moves dirty words out, so memory sees no reads once halt is up
	flushWritesOnly: assert property (@(posedge CLK) disable iff (rst)
		halt |-> !memReq.read)
		else $error("memory read requested while halt was high");

	// once the flush is over the flag only drops with reset
	flushedSticks: assert property (@(posedge CLK) disable iff (rst)
		flushed |=> flushed)
		else $error("flushed fell without a reset");

endmodule

/* run.sh */
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module dataCacheTb -o simv
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1

/* verilog/cacheArray.sv */
`timescale 1ns/1ps

module cacheArray
(
	input  logic                   CLK,
	input  logic                   rst,
	input  cachePkg::dpReq_t       dpReq,
	input  logic                   serve,        // the hit is taken this cycle
	input  cachePkg::frameSel_t    frame,
	input  logic                   fillWe,
	input  logic                   installTag,
	input  logic                   cleanFrame,
	input  logic                   scanMode,
	input  cachePkg::word_t        dload,
	output logic                   hit,
	output cachePkg::victimInfo_t  victim,
	output logic                   frameDirty,
	output cachePkg::word_t        frameWord,
	output cachePkg::word_t        hitWord
);

	// state bits per set and way, cleared on reset
	logic [cachePkg::SETS-1:0][cachePkg::WAYS-1:0] valid;
	logic [cachePkg::SETS-1:0][cachePkg::WAYS-1:0] dirty;
	logic [cachePkg::SETS-1:0]                     lru;  // names the least recently used way

	// tag and data storage
	logic [cachePkg::TAG_W-1:0] tags [cachePkg::SETS][cachePkg::WAYS];
	cachePkg::word_t            data [cachePkg::SETS][cachePkg::WAYS][2];  // two words per block

	logic [cachePkg::INDEX_W-1:0] reqIndex;
	logic [cachePkg::TAG_W-1:0]   reqTag;
	logic                         reqWordSel;
	logic                         hitWay0;
	logic                         hitWay1;
	logic                         hitWay;
	logic [cachePkg::INDEX_W-1:0] vicIndex;
	logic                         vicWay;

	assign reqIndex   = dpReq.addr.index;
	assign reqTag     = dpReq.addr.tag;
	assign reqWordSel = dpReq.addr.wordSel;

	// both ways of the indexed set are compared in parallel
	assign hitWay0 = valid[reqIndex][0] && (tags[reqIndex][0] == reqTag);
	assign hitWay1 = valid[reqIndex][1] && (tags[reqIndex][1] == reqTag);
	assign hit     = hitWay0 || hitWay1;
	assign hitWay  = hitWay1;  // a tag is never present in both ways

	assign hitWord = data[reqIndex][hitWay][reqWordSel];

	// while flushing the frame names the block under inspection, so the
	// victim port carries its tag for the write-back address
	always_comb
	begin
		vicIndex = reqIndex;
		vicWay   = lru[reqIndex];
		if (scanMode)
		begin
			vicIndex = frame.index;
			vicWay   = frame.way;
		end
		else if (!valid[reqIndex][0])
			vicWay = 1'b0;  // fill empty ways before evicting anything
		else if (!valid[reqIndex][1])
			vicWay = 1'b1;
	end

	assign victim.way   = vicWay;
	assign victim.valid = valid[vicIndex][vicWay];
	assign victim.dirty = dirty[vicIndex][vicWay];
	assign victim.tag   = tags[vicIndex][vicWay];

	assign frameDirty = dirty[frame.index][frame.way];
	assign frameWord  = data[frame.index][frame.way][frame.wordSel];

	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			valid <= '0;
			dirty <= '0;
			lru   <= '0;
		end
		else
		begin
			if (serve)
			begin
				lru[reqIndex] <= ~hitWay;  // the other way becomes the older one
				if (dpReq.write)
					dirty[reqIndex][hitWay] <= 1'b1;
			end
			if (installTag)
			begin
				valid[frame.index][frame.way] <= 1'b1;
				dirty[frame.index][frame.way] <= 1'b0;  // a fresh block matches memory
			end
			if (cleanFrame)
				dirty[frame.index][frame.way] <= 1'b0;
		end
	end

	// payload writes, serve and fill never happen in the same cycle
	always_ff @(posedge CLK)
	begin
		if (serve && dpReq.write)
			data[reqIndex][hitWay][reqWordSel] <= dpReq.store;
		if (fillWe)
			data[frame.index][frame.way][frame.wordSel] <= dload;
		if (installTag)
			tags[frame.index][frame.way] <= reqTag;  // the tag goes in with the last word
	end

endmodule

/* verilog/cacheController.sv */
`timescale 1ns/1ps

module cacheController
(
	input  logic                   CLK,
	input  logic                   rst,
	input  cachePkg::dpReq_t       dpReq,
	input  logic                   halt,
	input  logic                   hit,
	input  cachePkg::victimInfo_t  victim,
	input  logic                   frameDirty,
	input  cachePkg::word_t        frameWord,
	input  logic                   dwait,
	output logic                   dhit,
	output logic                   flushed,
	output logic                   serve,
	output cachePkg::frameSel_t    frame,
	output logic                   fillWe,
	output logic                   installTag,
	output logic                   cleanFrame,
	output logic                   scanMode,
	output cachePkg::memReq_t      memReq
);

	typedef enum logic [2:0]
	{
		idle,
		writeBack0,
		writeBack1,
		fetch0,
		fetch1,
		flushScan,
		flushDone
	} state_t;

	state_t              state;
	state_t              nextState;
	logic [3:0]          scanCount;  // {index, way}, way changes fastest
	logic                scanLast;
	logic                reqValid;
	logic                done;        // memory transfer completes at this edge
	cachePkg::cacheAddr_t wbAddr;
	cachePkg::cacheAddr_t fetchAddr;

	assign reqValid = dpReq.read || dpReq.write;
	assign done     = !dwait;
	assign scanLast = (scanCount == 4'd15);

	// a hit is only served from idle and never once halt is up
	assign dhit    = (state == idle) && !halt && reqValid && hit;
	assign serve   = dhit;
	assign flushed = (state == flushDone);

	// frame follows the scan counter while flushing, else the request set
	always_comb
	begin
		frame.index   = scanMode ? scanCount[3:1] : dpReq.addr.index;
		frame.way     = scanMode ? scanCount[0] : victim.way;
		frame.wordSel = (state == writeBack1) || (state == fetch1);  // second word of the block
	end

	// write-back goes to the victim's home address, fetch to the requested block
	always_comb
	begin
		wbAddr.tag        = victim.tag;
		wbAddr.index      = frame.index;
		wbAddr.wordSel    = frame.wordSel;
		wbAddr.byteSel    = 2'b00;
		fetchAddr.tag     = dpReq.addr.tag;
		fetchAddr.index   = dpReq.addr.index;
		fetchAddr.wordSel = frame.wordSel;
		fetchAddr.byteSel = 2'b00;
	end

	always_comb
	begin
		memReq.read  = (state == fetch0) || (state == fetch1);
		memReq.write = (state == writeBack0) || (state == writeBack1);
		memReq.addr  = memReq.write ? wbAddr : fetchAddr;
		memReq.store = frameWord;  // the frame points at the word being written back
	end

	// storage updates line up with the edge that completes each transfer
	assign fillWe     = ((state == fetch0) || (state == fetch1)) && done;
	assign installTag = (state == fetch1) && done;
	assign cleanFrame = (state == writeBack1) && done;

	always_comb
	begin
		nextState = state;
		case (state)
			idle:
			begin
				if (halt)
					nextState = flushScan;
				else if (reqValid && !hit)
					nextState = (victim.valid && victim.dirty) ? writeBack0 : fetch0;
			end
			writeBack0:
				if (done)
					nextState = writeBack1;
			writeBack1:
			begin
				if (done && scanMode)
					nextState = scanLast ? flushDone : flushScan;
				else if (done)
					nextState = fetch0;  // victim is clean now, go get the new block
			end
			fetch0:
				if (done)
					nextState = fetch1;
			fetch1:
				if (done)
					nextState = idle;  // the request hits on the next cycle
			flushScan:
			begin
				if (frameDirty)
					nextState = writeBack0;
				else if (scanLast)
					nextState = flushDone;
			end
			flushDone:
				nextState = flushDone;  // only reset leaves this state
			default:
				nextState = idle;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			state     <= idle;
			scanMode  <= 1'b0;
			scanCount <= 4'd0;
		end
		else
		begin
			state <= nextState;
			if ((state == idle) && halt)
			begin
				scanMode  <= 1'b1;  // stays set through the rest of the run
				scanCount <= 4'd0;
			end
			// advance past a clean frame, or past a dirty one once it is written
			if (((state == flushScan) && !frameDirty && !scanLast) ||
				((state == writeBack1) && done && scanMode && !scanLast))
				scanCount <= scanCount + 4'd1;
		end
	end

endmodule

/* verilog/cachePkg.sv */
package cachePkg;

	// geometry of the cache, fixed for two words per block
	parameter int WORD_W  = 32;
	parameter int TAG_W   = 26;
	parameter int INDEX_W = 3;
	parameter int SETS    = 8;  // one set per index value
	parameter int WAYS    = 2;

	typedef logic [WORD_W-1:0] word_t;

	// byte address as the cache sees it, tag in the top bits
	typedef struct packed {
		logic [TAG_W-1:0]   tag;
		logic [INDEX_W-1:0] index;
		logic               wordSel;  // picks one of the two words in a block
		logic [1:0]         byteSel;  // always word aligned, carried only for the address
	} cacheAddr_t;

	// request from the datapath, held until dhit
	typedef struct packed {
		logic       read;
		logic       write;
		cacheAddr_t addr;
		word_t      store;
	} dpReq_t;

	// request to memory, held until dwait drops
	typedef struct packed {
		logic  read;
		logic  write;
		word_t addr;
		word_t store;
	} memReq_t;

	// one word slot of storage, used for fill, write-back and flush
	typedef struct packed {
		logic [INDEX_W-1:0] index;
		logic               way;
		logic               wordSel;
	} frameSel_t;

	// replacement candidate, or the scanned block while flushing
	typedef struct packed {
		logic             way;
		logic             valid;
		logic             dirty;
		logic [TAG_W-1:0] tag;
	} victimInfo_t;

endpackage

/* verilog/dataCache.sv */
`timescale 1ns/1ps

module dataCache
(
	input  logic                CLK,
	input  logic                rst,
	input  cachePkg::dpReq_t    dpReq,
	input  logic                halt,
	output logic                dhit,
	output cachePkg::word_t     dmemLoad,
	output logic                flushed,
	output cachePkg::memReq_t   memReq,
	input  cachePkg::word_t     dload,
	input  logic                dwait
);

	logic                  hit;
	cachePkg::victimInfo_t victim;
	logic                  frameDirty;
	cachePkg::word_t       frameWord;
	logic                  serve;
	cachePkg::frameSel_t   frame;
	logic                  fillWe;
	logic                  installTag;
	logic                  cleanFrame;
	logic                  scanMode;

	// storage, lookup and LRU state
	cacheArray array0
	(
		.CLK        (CLK),
		.rst        (rst),
		.dpReq      (dpReq),
		.serve      (serve),
		.frame      (frame),
		.fillWe     (fillWe),
		.installTag (installTag),
		.cleanFrame (cleanFrame),
		.scanMode   (scanMode),
		.dload      (dload),
		.hit        (hit),
		.victim     (victim),
		.frameDirty (frameDirty),
		.frameWord  (frameWord),
		.hitWord    (dmemLoad)  // read data goes straight to the datapath
	);

	// miss, write-back and flush sequencing on the memory port
	cacheController ctrl0
	(
		.CLK        (CLK),
		.rst        (rst),
		.dpReq      (dpReq),
		.halt       (halt),
		.hit        (hit),
		.victim     (victim),
		.frameDirty (frameDirty),
		.frameWord  (frameWord),
		.dwait      (dwait),
		.dhit       (dhit),
		.flushed    (flushed),
		.serve      (serve),
		.frame      (frame),
		.fillWe     (fillWe),
		.installTag (installTag),
		.cleanFrame (cleanFrame),
		.scanMode   (scanMode),
		.memReq     (memReq)
	);

endmodule

/* vlog.f */
verilog/cachePkg.sv
verilog/cacheArray.sv
verilog/cacheController.sv
verilog/dataCache.sv
bench/dataCache_checker.sv
bench/dataCacheTb.sv
